//--- design/udp_rx_pkg.sv
package udp_rx_pkg;

    // control sequence for one datagram
    typedef enum logic [3:0] {
        IDLE     = 4'h8,
        CAPTURE  = 4'h9,
        WAIT_END = 4'hA,
        UNPACK   = 4'hB
    } rx_state_t;

    // payload and image sizes
    parameter int BYTE_W      = 8;
    parameter int IMAGE_BYTES = 12;
    parameter int IMAGE_W     = 96;

    // receive buffer side
    parameter int RX_ADDR_W = 11;
    parameter int RX_LEN_W  = 16;

    // largest FIFO the fill count can describe
    parameter int FIFO_MAX_DEPTH = 256;
    parameter int FIFO_CNT_W     = $clog2(FIFO_MAX_DEPTH + 1);

endpackage

//--- design/led_disp_pkg.sv
package led_disp_pkg;

    // image is shown four bytes at a time
    parameter int PAGE_COUNT = 3;

    // one LED per bit of a page
    parameter int PAGE_W = 32;

    // one-hot page indicator
    parameter int LEC_W = 4;

    // page index, wide enough for PAGE_COUNT
    parameter int PAGE_IDX_W = 2;

endpackage

//--- design/byte_fifo_if.sv
`timescale 1ns/1ps

interface byte_fifo_if;

    logic                                wr_en;
    logic [udp_rx_pkg::BYTE_W-1:0]       wdata;
    logic                                rd_en;
    logic [udp_rx_pkg::BYTE_W-1:0]       rdata;
    logic [udp_rx_pkg::FIFO_CNT_W-1:0]   count;
    logic                                empty;

    modport writer (
        output wr_en, wdata
    );

    // rdata follows rd_en by one cycle
    modport reader (
        output rd_en,
        input  rdata, count, empty
    );

    modport storage (
        input  wr_en, wdata, rd_en,
        output rdata, count, empty
    );

endinterface

//--- design/rx_ctrl_fsm.sv
`timescale 1ns/1ps

module rx_ctrl_fsm (
    input  logic sys_clk,
    input  logic rst,
    input  logic udp_rx_busy,
    input  logic cap_done,
    input  logic unpack_done,
    output logic cap_start,
    output logic unpack_start
);

    udp_rx_pkg::rx_state_t state;
    logic                  busy_q;
    logic                  busy_rise;

    assign busy_rise = udp_rx_busy && !busy_q;

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            busy_q <= 1'b0;
            state  <= udp_rx_pkg::IDLE;
        end else begin
            busy_q <= udp_rx_busy;
            case (state)
                udp_rx_pkg::IDLE: begin
                    if (busy_rise) begin
                        state <= udp_rx_pkg::CAPTURE;
                    end
                end
                udp_rx_pkg::CAPTURE: begin
                    if (cap_done) begin
                        state <= udp_rx_pkg::WAIT_END;
                    end
                end
                // payload stays valid until the receiver drops busy
                udp_rx_pkg::WAIT_END: begin
                    if (!udp_rx_busy) begin
                        state <= udp_rx_pkg::UNPACK;
                    end
                end
                udp_rx_pkg::UNPACK: begin
                    if (unpack_done) begin
                        state <= udp_rx_pkg::IDLE;
                    end
                end
                default: state <= udp_rx_pkg::IDLE;
            endcase
        end
    end

    assign cap_start    = (state == udp_rx_pkg::CAPTURE);
    assign unpack_start = (state == udp_rx_pkg::UNPACK);

endmodule

//--- design/payload_capture.sv
`timescale 1ns/1ps

module payload_capture #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                               sys_clk,
    input  logic                               rst,
    input  logic                               cap_start,
    input  logic [udp_rx_pkg::RX_LEN_W-1:0]    udp_rx_len,
    input  logic [udp_rx_pkg::BYTE_W-1:0]      udp_rxd,
    output logic [udp_rx_pkg::RX_ADDR_W-1:0]   udp_rx_addr,
    output logic                               cap_done,
    byte_fifo_if.writer                        fifo
);

    localparam int LEN_W = udp_rx_pkg::RX_LEN_W;
    localparam logic [LEN_W-1:0] DEPTH_LEN = LEN_W'(FIFO_DEPTH);

    logic             start_q;
    logic             start_pulse;
    logic [LEN_W-1:0] capped_len;
    logic [LEN_W-1:0] remaining;
    logic             active;
    logic             issue;
    logic             last_q;
    logic             wr_q;

    assign start_pulse = cap_start && !start_q;
    // never write more than the FIFO holds
    assign capped_len  = (udp_rx_len > DEPTH_LEN) ? DEPTH_LEN : udp_rx_len;
    assign issue       = active && (remaining != '0);

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            start_q     <= 1'b0;
            active      <= 1'b0;
            remaining   <= '0;
            udp_rx_addr <= '0;
            wr_q        <= 1'b0;
            last_q      <= 1'b0;
            cap_done    <= 1'b0;
        end else begin
            start_q <= cap_start;
            if (start_pulse) begin
                udp_rx_addr <= '0;
                remaining   <= capped_len;
                active      <= (capped_len != '0);
            end else if (issue) begin
                udp_rx_addr <= udp_rx_addr + 1'b1;
                remaining   <= remaining - 1'b1;
                if (remaining == LEN_W'(1)) begin
                    active <= 1'b0;
                end
            end
            // byte for this address returns next cycle
            wr_q     <= issue;
            last_q   <= (issue && remaining == LEN_W'(1)) ||
                        (start_pulse && capped_len == '0);
            cap_done <= last_q;
        end
    end

    assign fifo.wr_en = wr_q;
    assign fifo.wdata = udp_rxd;

endmodule

//--- design/byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic          sys_clk,
    input  logic          rst,
    byte_fifo_if.storage  fifo
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = udp_rx_pkg::FIFO_CNT_W;
    localparam logic [PTR_W-1:0] LAST_PTR  = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] DEPTH_CNT = CNT_W'(FIFO_DEPTH);

    logic [udp_rx_pkg::BYTE_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]              wptr;
    logic [PTR_W-1:0]              rptr;
    logic [CNT_W-1:0]              count_q;
    logic                          do_wr;
    logic                          do_rd;

    // writes to a full FIFO are dropped
    assign do_wr = fifo.wr_en && (count_q != DEPTH_CNT);
    assign do_rd = fifo.rd_en && (count_q != '0);

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            wptr    <= '0;
            rptr    <= '0;
            count_q <= '0;
        end else begin
            if (do_wr) begin
                wptr <= (wptr == LAST_PTR) ? '0 : wptr + 1'b1;
            end
            if (do_rd) begin
                rptr <= (rptr == LAST_PTR) ? '0 : rptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (do_wr) begin
            mem[wptr] <= fifo.wdata;
        end
        if (do_rd) begin
            fifo.rdata <= mem[rptr];
        end
    end

    assign fifo.count = count_q;
    assign fifo.empty = (count_q == '0);

endmodule

//--- design/frame_unpack.sv
`timescale 1ns/1ps

module frame_unpack (
    input  logic                              sys_clk,
    input  logic                              rst,
    input  logic                              unpack_start,
    byte_fifo_if.reader                       fifo,
    output logic [udp_rx_pkg::IMAGE_W-1:0]    image,
    output logic                              image_load,
    output logic                              unpack_done
);

    localparam int CNT_W = udp_rx_pkg::FIFO_CNT_W;
    localparam int IDX_W = $clog2(udp_rx_pkg::IMAGE_BYTES + 1);
    localparam int BW    = udp_rx_pkg::BYTE_W;

    logic             start_q;
    logic             start_pulse;
    logic             active;
    logic [CNT_W-1:0] rd_left;
    logic             rd_q;
    logic [IDX_W-1:0] idx;
    logic             finish;

    assign start_pulse = unpack_start && !start_q;
    assign fifo.rd_en  = active && (rd_left != '0) && !fifo.empty;
    // last byte has landed once nothing is left and nothing is in flight
    assign finish      = active && (rd_left == '0) && !rd_q;

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            start_q     <= 1'b0;
            active      <= 1'b0;
            rd_left     <= '0;
            rd_q        <= 1'b0;
            idx         <= '0;
            image_load  <= 1'b0;
            unpack_done <= 1'b0;
        end else begin
            start_q     <= unpack_start;
            rd_q        <= fifo.rd_en;
            image_load  <= finish;
            unpack_done <= finish;
            if (start_pulse) begin
                active  <= 1'b1;
                rd_left <= fifo.count;
                idx     <= '0;
            end else begin
                if (fifo.rd_en) begin
                    rd_left <= rd_left - 1'b1;
                end
                if (rd_q && idx < IDX_W'(udp_rx_pkg::IMAGE_BYTES)) begin
                    idx <= idx + 1'b1;
                end
                if (finish) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // byte 0 lands in the top slot, extra bytes fall away
    always_ff @(posedge sys_clk) begin
        if (start_pulse) begin
            image <= '0;
        end else if (rd_q && idx < IDX_W'(udp_rx_pkg::IMAGE_BYTES)) begin
            image[udp_rx_pkg::IMAGE_W - 1 - BW * idx -: BW] <= fifo.rdata;
        end
    end

endmodule

//--- design/key_debounce.sv
`timescale 1ns/1ps

module key_debounce #(
    parameter int DEBOUNCE_CYCLES = 20000
) (
    input  logic sys_clk,
    input  logic rst,
    input  logic key,
    output logic press
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
    localparam logic [CNT_W-1:0] LIMIT    = CNT_W'(DEBOUNCE_CYCLES);
    localparam logic [CNT_W-1:0] PRE_LIMIT = CNT_W'(DEBOUNCE_CYCLES - 1);

    logic             key_m;
    logic             key_s;
    logic [CNT_W-1:0] low_cnt;

    // keys idle high
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            key_m <= 1'b1;
            key_s <= 1'b1;
        end else begin
            key_m <= key;
            key_s <= key_m;
        end
    end

    // count saturates at the limit, so a held key fires once
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            low_cnt <= '0;
            press   <= 1'b0;
        end else begin
            press <= 1'b0;
            if (key_s) begin
                low_cnt <= '0;
            end else if (low_cnt != LIMIT) begin
                low_cnt <= low_cnt + 1'b1;
                press   <= (low_cnt == PRE_LIMIT);
            end
        end
    end

endmodule

//--- design/led_pager.sv
`timescale 1ns/1ps

module led_pager (
    input  logic                               sys_clk,
    input  logic                               rst,
    input  logic [udp_rx_pkg::IMAGE_W-1:0]     image,
    input  logic                               image_load,
    input  logic                               page_up,
    input  logic                               page_down,
    output logic [led_disp_pkg::PAGE_W-1:0]    led,
    output logic [led_disp_pkg::LEC_W-1:0]     lec
);

    localparam int IDX_W = led_disp_pkg::PAGE_IDX_W;
    localparam logic [IDX_W-1:0] LAST_PAGE = IDX_W'(led_disp_pkg::PAGE_COUNT - 1);

    logic [udp_rx_pkg::IMAGE_W-1:0] shown;
    logic [IDX_W-1:0]               page;

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            shown <= '0;
        end else if (image_load) begin
            shown <= image;
        end
    end

    // both keys at once cancel out
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            page <= '0;
        end else if (page_up && !page_down) begin
            page <= (page == LAST_PAGE) ? '0 : page + 1'b1;
        end else if (page_down && !page_up) begin
            page <= (page == '0) ? LAST_PAGE : page - 1'b1;
        end
    end

    // page 0 takes the top four bytes
    assign led = shown[udp_rx_pkg::IMAGE_W - 1 - led_disp_pkg::PAGE_W * page
                       -: led_disp_pkg::PAGE_W];
    assign lec = led_disp_pkg::LEC_W'(1) << page;

endmodule

//--- design/udp_led_top.sv
`timescale 1ns/1ps

module udp_led_top #(
    parameter int FIFO_DEPTH      = 16,
    parameter int DEBOUNCE_CYCLES = 20000
) (
    input  logic                               sys_clk,
    input  logic                               rst,
    input  logic                               udp_rx_busy,
    input  logic [udp_rx_pkg::RX_LEN_W-1:0]    udp_rx_len,
    input  logic [udp_rx_pkg::BYTE_W-1:0]      udp_rxd,
    input  logic [1:0]                         key,
    output logic [udp_rx_pkg::RX_ADDR_W-1:0]   udp_rx_addr,
    output logic [led_disp_pkg::PAGE_W-1:0]    led,
    output logic [led_disp_pkg::LEC_W-1:0]     lec
);

    logic                           cap_start;
    logic                           cap_done;
    logic                           unpack_start;
    logic                           unpack_done;
    logic [udp_rx_pkg::IMAGE_W-1:0] image;
    logic                           image_load;
    logic                           press_up;
    logic                           press_down;

    byte_fifo_if fifo_bus ();

    rx_ctrl_fsm u_ctrl (
        .sys_clk      (sys_clk),
        .rst          (rst),
        .udp_rx_busy  (udp_rx_busy),
        .cap_done     (cap_done),
        .unpack_done  (unpack_done),
        .cap_start    (cap_start),
        .unpack_start (unpack_start)
    );

    payload_capture #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_capture (
        .sys_clk     (sys_clk),
        .rst         (rst),
        .cap_start   (cap_start),
        .udp_rx_len  (udp_rx_len),
        .udp_rxd     (udp_rxd),
        .udp_rx_addr (udp_rx_addr),
        .cap_done    (cap_done),
        .fifo        (fifo_bus.writer)
    );

    byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .sys_clk (sys_clk),
        .rst     (rst),
        .fifo    (fifo_bus.storage)
    );

    frame_unpack u_unpack (
        .sys_clk      (sys_clk),
        .rst          (rst),
        .unpack_start (unpack_start),
        .fifo         (fifo_bus.reader),
        .image        (image),
        .image_load   (image_load),
        .unpack_done  (unpack_done)
    );

    led_pager u_pager (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .image      (image),
        .image_load (image_load),
        .page_up    (press_up),
        .page_down  (press_down),
        .led        (led),
        .lec        (lec)
    );

    // key[1] steps up, key[0] steps down
    key_debounce #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_key_up (
        .sys_clk (sys_clk),
        .rst     (rst),
        .key     (key[1]),
        .press   (press_up)
    );

    key_debounce #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_key_down (
        .sys_clk (sys_clk),
        .rst     (rst),
        .key     (key[0]),
        .press   (press_down)
    );

endmodule

//--- dv/udp_led_tb.sv
`timescale 1ns/1ps

module udp_led_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int DEB_CYCLES   = 16;
    localparam int BUF_SIZE     = 2 ** udp_rx_pkg::RX_ADDR_W;
    localparam int LOAD_WAIT    = 64;
    localparam int BUSY_HOLD    = 40;
    localparam int NUM_TESTS    = 6;
    localparam int TEST_CYCLES  = 400;
    localparam int MARGIN       = 500;

    logic                             sys_clk = 1'b0;
    logic                             rst;
    logic                             udp_rx_busy;
    logic [udp_rx_pkg::RX_LEN_W-1:0]  udp_rx_len;
    logic [udp_rx_pkg::BYTE_W-1:0]    udp_rxd;
    logic [1:0]                       key;
    logic [udp_rx_pkg::RX_ADDR_W-1:0] udp_rx_addr;
    logic [led_disp_pkg::PAGE_W-1:0]  led;
    logic [led_disp_pkg::LEC_W-1:0]   lec;

    logic [7:0] rx_buf [BUF_SIZE];
    logic [7:0] exp_img [udp_rx_pkg::IMAGE_BYTES];
    int         seed = 32'h3154_a94f;
    int         cur_page = 0;
    int         test_errors = 0;
    int         total_errors = 0;
    int         tests_run = 0;
    int         tests_bad = 0;

    udp_led_top #(
        .FIFO_DEPTH      (16),
        .DEBOUNCE_CYCLES (DEB_CYCLES)
    ) UUT (
        .sys_clk     (sys_clk),
        .rst         (rst),
        .udp_rx_busy (udp_rx_busy),
        .udp_rx_len  (udp_rx_len),
        .udp_rxd     (udp_rxd),
        .key         (key),
        .udp_rx_addr (udp_rx_addr),
        .led         (led),
        .lec         (lec)
    );

    always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

    // receive buffer answers an address one cycle later
    always @(posedge sys_clk) begin
        udp_rxd <= #1 rx_buf[udp_rx_addr];
    end

    initial begin
        #(CLK_PERIOD * (NUM_TESTS * TEST_CYCLES + MARGIN));
        $display("timeout: the run did not reach its end in time");
        $display("Some tests failed");
        $finish;
    end

    task automatic next_cycle();
        @(posedge sys_clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        total_errors += test_errors;
        if (test_errors != 0) begin
            tests_bad++;
            $display("test %s: FAIL with %0d errors", name, test_errors);
        end else begin
            $display("test %s: ok", name);
        end
        test_errors = 0;
    endtask

    // page p holds image bytes 4p..4p+3, byte 4p on top
    task automatic check_page();
        logic [31:0] exp_led;
        exp_led = {exp_img[4 * cur_page], exp_img[4 * cur_page + 1],
                   exp_img[4 * cur_page + 2], exp_img[4 * cur_page + 3]};
        check_value("led", exp_led, led);
        check_value("lec", 32'(1 << cur_page), 32'(lec));
    endtask

    // random payload, bytes past the length are nonzero on purpose
    task automatic fill_payload(input int len);
        for (int i = 0; i < 32; i++) begin
            rx_buf[i] = 8'($random(seed));
        end
        for (int i = 0; i < udp_rx_pkg::IMAGE_BYTES; i++) begin
            exp_img[i] = (i < len) ? rx_buf[i] : 8'h00;
        end
    endtask

    task automatic wait_led_change();
        logic [31:0] old_led;
        int          n;
        old_led = led;
        n = 0;
        while (led === old_led && n < LOAD_WAIT) begin
            next_cycle();
            n++;
        end
    endtask

    task automatic receive_payload(input int len, input bit second_rise);
        fill_payload(len);
        udp_rx_len = 16'(len);
        next_cycle();
        udp_rx_busy = 1'b1;
        if (second_rise) begin
            repeat (4) next_cycle();
            udp_rx_busy = 1'b0;
            next_cycle();
            // second datagram announces another length
            udp_rx_busy = 1'b1;
            udp_rx_len = 16'(2);
            next_cycle();
            check_value("state", 32'(udp_rx_pkg::CAPTURE), 32'(UUT.u_ctrl.state));
        end
        repeat (BUSY_HOLD) next_cycle();
        udp_rx_busy = 1'b0;
        wait_led_change();
    endtask

    // idx 1 is the up key, idx 0 the down key
    task automatic press_key(input int idx, input int hold);
        key[idx] = 1'b0;
        repeat (hold) next_cycle();
        key[idx] = 1'b1;
        repeat (8) next_cycle();
        if (hold >= DEB_CYCLES) begin
            if (idx == 1) begin
                cur_page = (cur_page + 1) % led_disp_pkg::PAGE_COUNT;
            end else begin
                cur_page = (cur_page + led_disp_pkg::PAGE_COUNT - 1) % led_disp_pkg::PAGE_COUNT;
            end
        end
    endtask

    task automatic test_reset();
        check_value("led", 32'h0, led);
        check_value("lec", 32'h1, 32'(lec));
        check_value("udp_rx_addr", 32'h0, 32'(udp_rx_addr));
        finish_test("reset");
    endtask

    task automatic test_full_payload();
        receive_payload(12, 1'b0);
        check_page();
        finish_test("full_payload");
    endtask

    task automatic test_short_payload();
        receive_payload(5, 1'b0);
        check_page();
        press_key(1, DEB_CYCLES + 8);
        check_page();
        press_key(0, DEB_CYCLES + 8);
        check_page();
        finish_test("short_payload");
    endtask

    task automatic test_long_payload();
        receive_payload(16, 1'b0);
        check_page();
        press_key(1, DEB_CYCLES + 8);
        press_key(1, DEB_CYCLES + 8);
        check_page();
        finish_test("long_payload");
    endtask

    task automatic test_page_wrap();
        press_key(1, DEB_CYCLES + 8);
        check_page();
        press_key(0, DEB_CYCLES + 8);
        check_value("lec", 32'h4, 32'(lec));
        check_page();
        // one cycle short of counting
        press_key(1, DEB_CYCLES - 1);
        check_page();
        press_key(1, DEB_CYCLES + 8);
        check_page();
        finish_test("page_wrap");
    endtask

    task automatic test_busy_retrigger();
        receive_payload(12, 1'b1);
        check_page();
        repeat (BUSY_HOLD) next_cycle();
        check_page();
        finish_test("busy_retrigger");
    endtask

    initial begin
        for (int i = 0; i < BUF_SIZE; i++) begin
            rx_buf[i] = 8'(i ^ (i >> 3) ^ (i >> 8));
        end
        rst = 1'b1;
        udp_rx_busy = 1'b0;
        udp_rx_len = '0;
        udp_rxd = '0;
        key = 2'b11;
        repeat (8) @(posedge sys_clk);
        #1;
        rst = 1'b0;
        next_cycle();

        test_reset();
        test_full_payload();
        test_short_payload();
        test_long_payload();
        test_page_wrap();
        test_busy_retrigger();

        $display("tests run %0d, tests with errors %0d, check errors %0d",
                 tests_run, tests_bad, total_errors);
        if (tests_bad == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
design/udp_rx_pkg.sv
design/led_disp_pkg.sv
design/byte_fifo_if.sv
design/rx_ctrl_fsm.sv
design/payload_capture.sv
design/byte_fifo.sv
design/frame_unpack.sv
design/key_debounce.sv
design/led_pager.sv
design/udp_led_top.sv
dv/udp_led_tb.sv

//--- Bender.yml
package:
  name: udp_led

sources:
  - files:
      - design/udp_rx_pkg.sv
      - design/led_disp_pkg.sv
      - design/byte_fifo_if.sv
      - design/rx_ctrl_fsm.sv
      - design/payload_capture.sv
      - design/byte_fifo.sv
      - design/frame_unpack.sv
      - design/key_debounce.sv
      - design/led_pager.sv
      - design/udp_led_top.sv
  - target: test
    files:
      - dv/udp_led_tb.sv
